// File: tlp_hdr_pkg.sv
package tlp_hdr_pkg;

  localparam int DW_W    = 32;            // One dword
  localparam int BEAT_W  = 128;           // DLL beat width
  localparam int BEAT_DW = BEAT_W / DW_W; // Dwords per beat
  localparam int LEN_W   = 10;            // Length field in DW0

  // Fmt codes, bit 0 selects 4DW header and bit 1 marks a data payload
  typedef enum logic [2:0] {
    FMT_3DW_NODATA = 3'b000,
    FMT_4DW_NODATA = 3'b001,
    FMT_3DW_DATA   = 3'b010,
    FMT_4DW_DATA   = 3'b011
  } fmt_e;

  localparam logic [4:0] TYPE_MEM  = 5'b00000; // MRd / MWr
  localparam logic [4:0] TYPE_CFG0 = 5'b00100; // Type 0 config
  localparam logic [4:0] TYPE_CPL  = 5'b01010; // Cpl / CplD

  typedef struct packed {
    fmt_e             fmt;
    logic [4:0]       typ;
    logic [13:0]      attr;   // TC, TD, EP and attributes, not decoded
    logic [LEN_W-1:0] length;
  } hdr_dw0_t;

  typedef struct packed {
    logic [15:0] requester_id;
    logic [7:0]  tag;
    logic [3:0]  last_be;
    logic [3:0]  first_be;
  } hdr_dw1_t;

  // Address view, lower_addr is what a completion reports back
  typedef struct packed {
    logic [DW_W-8:0] upper;
    logic [6:0]      lower_addr;
  } addr_dw_t;

  // Config view, register number is split into extended and base parts
  typedef struct packed {
    logic [7:0] bus;
    logic [4:0] dev;
    logic [2:0] func;
    logic [3:0] rsvd_hi;
    logic [3:0] ext_reg;
    logic [5:0] reg_num;
    logic [1:0] rsvd_lo;
  } cfg_dw_t;

  typedef union packed {
    addr_dw_t addr;
    cfg_dw_t  cfg;
  } hdr_dw2_u;

  // DW0 sits in the low bits of the header beat
  typedef struct packed {
    hdr_dw2_u dw3;  // Low address on 4DW, first payload DW on 3DW
    hdr_dw2_u dw2;
    hdr_dw1_t dw1;
    hdr_dw0_t dw0;
  } tlp_hdr_t;

endpackage

// File: tlp_rx_pkg.sv
package tlp_rx_pkg;

  typedef enum logic [2:0] {
    MRD,
    MWR,
    CFGRD,
    CFGWR,
    CPL_DISCARD,  // Received completions are dropped
    UNSUP
  } pkt_kind_e;

  // Completion status codes as carried on the wire
  typedef enum logic [2:0] {
    SC = 3'b000,
    UR = 3'b001
  } cpl_status_e;

  typedef struct packed {
    logic [tlp_hdr_pkg::BEAT_W-1:0] data;
    logic                           sop;
    logic                           eop;
  } rx_beat_t;

  typedef struct packed {
    tlp_hdr_pkg::tlp_hdr_t         hdr;
    pkt_kind_e                     kind;
    logic                          is_4dw;
    logic [tlp_hdr_pkg::LEN_W-1:0] length;
    logic                          has_payload; // Only MWr with data goes to the aligner
    logic                          hdr_eop;     // Header beat closed the packet
  } hdr_info_t;

  typedef struct packed {
    logic [tlp_hdr_pkg::BEAT_W-1:0]   data;
    logic [2*tlp_hdr_pkg::DW_W-1:0]   addr;  // Valid on the sop beat only
    logic [tlp_hdr_pkg::BEAT_W/8-1:0] be;
    logic                             sop;
    logic                             eop;
  } memwr_beat_t;

  typedef struct packed {
    logic [15:0] requester_id;
    logic [7:0]  tag;
    logic [11:0] byte_count;
    logic [6:0]  lower_addr;
    logic [3:0]  first_be;
    logic [3:0]  last_be;
    cpl_status_e status;
  } cpl_cmd_t;

  typedef struct packed {
    logic                         is_read;
    logic [15:0]                  requester_id;
    logic [7:0]                   tag;
    logic [3:0]                   first_be;
    logic [9:0]                   reg_num;
    logic [tlp_hdr_pkg::DW_W-1:0] data;
  } cfg_req_t;

endpackage

// File: tlp_hdr_decoder.sv
`timescale 1ns/1ns

module tlp_hdr_decoder (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  hdr_take_i,
  input  tlp_rx_pkg::rx_beat_t  rx_i,
  output tlp_rx_pkg::hdr_info_t hdr_info_o
);
  import tlp_hdr_pkg::*;
  import tlp_rx_pkg::*;

  tlp_hdr_t         hdr_in;
  tlp_hdr_t         hdr_q;
  pkt_kind_e        kind_d;
  pkt_kind_e        kind_q;
  logic             is_4dw_q;
  logic             has_payload_q;
  logic             hdr_eop_q;
  logic [LEN_W-1:0] length_q;

  assign hdr_in = rx_i.data; // Header beat viewed as four dwords

  // Fmt picks header size and data, Type picks the request class
  always_comb begin
    kind_d = UNSUP;
    case (hdr_in.dw0.fmt)
      FMT_3DW_NODATA: begin
        if (hdr_in.dw0.typ == TYPE_MEM)       kind_d = MRD;
        else if (hdr_in.dw0.typ == TYPE_CFG0) kind_d = CFGRD;
        else if (hdr_in.dw0.typ == TYPE_CPL)  kind_d = CPL_DISCARD;
      end
      FMT_3DW_DATA: begin
        if (hdr_in.dw0.typ == TYPE_MEM)       kind_d = MWR;
        else if (hdr_in.dw0.typ == TYPE_CFG0) kind_d = CFGWR;
        else if (hdr_in.dw0.typ == TYPE_CPL)  kind_d = CPL_DISCARD; // CplD tail dropped
      end
      FMT_4DW_NODATA: if (hdr_in.dw0.typ == TYPE_MEM) kind_d = MRD;
      FMT_4DW_DATA:   if (hdr_in.dw0.typ == TYPE_MEM) kind_d = MWR;
      default:        kind_d = UNSUP;
    endcase
  end

  always_ff @(posedge clk) begin
    if (hdr_take_i) hdr_q <= hdr_in; // Raw header dwords
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      kind_q        <= UNSUP;
      is_4dw_q      <= 1'b0;
      length_q      <= '0;
      has_payload_q <= 1'b0;
      hdr_eop_q     <= 1'b1;
    end else if (hdr_take_i) begin
      kind_q        <= kind_d;
      is_4dw_q      <= hdr_in.dw0.fmt[0];
      length_q      <= hdr_in.dw0.length;
      has_payload_q <= (kind_d == MWR) && (hdr_in.dw0.length != '0);
      hdr_eop_q     <= rx_i.eop;
    end
  end

  always_comb begin
    hdr_info_o.hdr         = hdr_q;
    hdr_info_o.kind        = kind_q;
    hdr_info_o.is_4dw      = is_4dw_q;
    hdr_info_o.length      = length_q;
    hdr_info_o.has_payload = has_payload_q;
    hdr_info_o.hdr_eop     = hdr_eop_q;
  end

endmodule

// File: tlp_rx_ctrl.sv
`timescale 1ns/1ns

module tlp_rx_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  rx_valid_i,
  input  logic                  rx_sop_i,
  input  logic                  rx_eop_i,
  input  tlp_rx_pkg::hdr_info_t hdr_info_i,
  input  logic                  route_done_i,
  input  logic                  data_ready_i,
  input  logic                  data_done_i,
  output logic                  hdr_take_o,
  output logic                  route_en_o,
  output logic                  data_en_o,
  output logic                  rx_ready_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LATCH,  // Decoded header settles in the register
    ST_ROUTE,
    ST_DATA,
    ST_DROP
  } state_e;

  state_e state_q;
  state_e state_d;

  // Header accepted and latched in the same cycle
  assign hdr_take_o = (state_q == ST_IDLE) && rx_valid_i && rx_sop_i;
  assign route_en_o = (state_q == ST_ROUTE);
  assign data_en_o  = (state_q == ST_DATA);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) state_q <= ST_IDLE;
    else        state_q <= state_d;
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:  if (hdr_take_o) state_d = ST_LATCH;
      ST_LATCH: state_d = ST_ROUTE;
      ST_ROUTE: begin
        // Hold until the router's output handshake completes
        if (route_done_i) begin
          if (hdr_info_i.has_payload) state_d = ST_DATA;
          else if (!hdr_info_i.hdr_eop) state_d = ST_DROP; // Tail to consume
          else                          state_d = ST_IDLE;
        end
      end
      ST_DATA:  if (data_done_i) state_d = ST_IDLE;
      ST_DROP:  if (rx_valid_i && rx_eop_i) state_d = ST_IDLE;
      default:  state_d = ST_IDLE;
    endcase
  end

  always_comb begin
    case (state_q)
      ST_IDLE: rx_ready_o = 1'b1;
      ST_DATA: rx_ready_o = data_ready_i; // Write sink back-pressure
      ST_DROP: rx_ready_o = 1'b1;         // Swallow beats
      default: rx_ready_o = 1'b0;
    endcase
  end

endmodule

// File: tlp_req_router.sv
`timescale 1ns/1ns

module tlp_req_router (
  input  logic                  route_en_i,
  input  tlp_rx_pkg::hdr_info_t hdr_info_i,
  output tlp_rx_pkg::cpl_cmd_t  cpl_cmd_o,
  output logic                  cpl_cmd_valid_o,
  input  logic                  cpl_cmd_ready_i,
  output tlp_rx_pkg::cfg_req_t  cfg_req_o,
  output logic                  cfg_req_valid_o,
  input  logic                  cfg_req_ready_i,
  output logic                  route_done_o
);
  import tlp_rx_pkg::*;

  logic is_ur;

  assign is_ur = (hdr_info_i.kind == UNSUP);

  // Payloads follow the latched header, stable through the route state
  always_comb begin
    cpl_cmd_o.requester_id = hdr_info_i.hdr.dw1.requester_id;
    cpl_cmd_o.tag          = hdr_info_i.hdr.dw1.tag;
    cpl_cmd_o.first_be     = hdr_info_i.hdr.dw1.first_be;
    cpl_cmd_o.last_be      = hdr_info_i.hdr.dw1.last_be;
    cpl_cmd_o.status       = is_ur ? UR : SC;
    cpl_cmd_o.byte_count   = is_ur ? 12'd0 : {hdr_info_i.length, 2'b00}; // DW to bytes
    if (is_ur)                  cpl_cmd_o.lower_addr = '0;
    else if (hdr_info_i.is_4dw) cpl_cmd_o.lower_addr = hdr_info_i.hdr.dw3.addr.lower_addr;
    else                        cpl_cmd_o.lower_addr = hdr_info_i.hdr.dw2.addr.lower_addr;

    cfg_req_o.is_read      = (hdr_info_i.kind == CFGRD);
    cfg_req_o.requester_id = hdr_info_i.hdr.dw1.requester_id;
    cfg_req_o.tag          = hdr_info_i.hdr.dw1.tag;
    cfg_req_o.first_be     = hdr_info_i.hdr.dw1.first_be;
    cfg_req_o.reg_num      = {hdr_info_i.hdr.dw2.cfg.ext_reg, hdr_info_i.hdr.dw2.cfg.reg_num};
    // CfgWr carries its single data DW in the header beat
    cfg_req_o.data         = cfg_req_o.is_read ? '0 : hdr_info_i.hdr.dw3;
  end

  always_comb begin
    cpl_cmd_valid_o = 1'b0;
    cfg_req_valid_o = 1'b0;
    route_done_o    = 1'b0;
    if (route_en_i) begin
      case (hdr_info_i.kind)
        MRD, UNSUP: begin
          cpl_cmd_valid_o = 1'b1;
          route_done_o    = cpl_cmd_ready_i;
        end
        CFGRD, CFGWR: begin
          cfg_req_valid_o = 1'b1;
          route_done_o    = cfg_req_ready_i;
        end
        default: route_done_o = 1'b1; // MWr and completions pass at once
      endcase
    end
  end

endmodule

// File: tlp_memwr_aligner.sv
`timescale 1ns/1ns

module tlp_memwr_aligner (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    data_en_i,
  input  tlp_rx_pkg::hdr_info_t   hdr_info_i,
  input  tlp_rx_pkg::rx_beat_t    rx_i,
  input  logic                    rx_valid_i,
  output tlp_rx_pkg::memwr_beat_t memwr_o,
  output logic                    memwr_valid_o,
  input  logic                    memwr_ready_i,
  output logic                    data_ready_o,
  output logic                    data_done_o
);
  import tlp_hdr_pkg::*;

  logic [LEN_W:0]  sent_q;   // DWs already handed out
  logic [LEN_W:0]  len_ext;
  logic [LEN_W:0]  remain;
  logic [DW_W-1:0] hold_q;   // Top DW of the previous input beat
  logic [DW_W-1:0] held_dw;
  logic            flush_q;  // Last input beat left one DW behind
  logic            flush;
  logic            first;
  logic            last;
  logic            in_take;
  logic            out_take;

  assign len_ext = {1'b0, hdr_info_i.length};
  assign remain  = len_ext - sent_q;
  assign first   = (sent_q == '0);
  assign last    = (remain <= (LEN_W+1)'(BEAT_DW)); // Final DW lands in this beat

  // First held DW comes from the header beat itself
  assign held_dw = first ? hdr_info_i.hdr.dw3 : hold_q;

  // Length 1 on a 3DW header never sees a payload beat
  assign flush = !hdr_info_i.is_4dw && (flush_q || (first && hdr_info_i.hdr_eop));

  assign memwr_valid_o = data_en_i && (flush || rx_valid_i);
  assign data_ready_o  = memwr_ready_i && !flush; // No input taken during flush
  assign in_take       = data_en_i && rx_valid_i && data_ready_o;
  assign out_take      = memwr_valid_o && memwr_ready_i;
  assign data_done_o   = out_take && last;

  always_comb begin
    logic [LEN_W:0] idx;
    idx = '0;
    if (hdr_info_i.is_4dw) memwr_o.data = rx_i.data; // Already aligned
    else if (flush)        memwr_o.data = {{(BEAT_W-DW_W){1'b0}}, held_dw};
    else                   memwr_o.data = {rx_i.data[BEAT_W-DW_W-1:0], held_dw};

    if (!first)                 memwr_o.addr = '0;
    else if (hdr_info_i.is_4dw) memwr_o.addr = {hdr_info_i.hdr.dw2, hdr_info_i.hdr.dw3};
    else                        memwr_o.addr = {{DW_W{1'b0}}, hdr_info_i.hdr.dw2};

    // Per lane enables from the running DW index
    for (int i = 0; i < BEAT_DW; i++) begin
      idx = sent_q + (LEN_W+1)'(i);
      if (idx == '0)                memwr_o.be[4*i +: 4] = hdr_info_i.hdr.dw1.first_be;
      else if (idx == len_ext - 1'b1) memwr_o.be[4*i +: 4] = hdr_info_i.hdr.dw1.last_be;
      else if (idx < len_ext)       memwr_o.be[4*i +: 4] = 4'hF;
      else                          memwr_o.be[4*i +: 4] = 4'h0; // Past the end
    end

    memwr_o.sop = first;
    memwr_o.eop = last;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sent_q  <= '0;
      flush_q <= 1'b0;
    end else if (!data_en_i) begin
      sent_q  <= '0; // Rearm for the next write
      flush_q <= 1'b0;
    end else begin
      if (out_take) sent_q <= sent_q + (LEN_W+1)'(BEAT_DW);
      if (in_take && rx_i.eop && !last && !hdr_info_i.is_4dw)
        flush_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (in_take) hold_q <= rx_i.data[BEAT_W-1 -: DW_W]; // Carry into next beat
  end

endmodule

// File: tlp_rx_top.sv
`timescale 1ns/1ns

module tlp_rx_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  tlp_rx_pkg::rx_beat_t    rx_i,
  input  logic                    rx_valid_i,
  output logic                    rx_ready_o,
  output tlp_rx_pkg::memwr_beat_t memwr_o,
  output logic                    memwr_valid_o,
  input  logic                    memwr_ready_i,
  output tlp_rx_pkg::cpl_cmd_t    cpl_cmd_o,
  output logic                    cpl_cmd_valid_o,
  input  logic                    cpl_cmd_ready_i,
  output tlp_rx_pkg::cfg_req_t    cfg_req_o,
  output logic                    cfg_req_valid_o,
  input  logic                    cfg_req_ready_i
);
  import tlp_rx_pkg::*;

  hdr_info_t hdr_info;     // Latched header and class
  logic      hdr_take;
  logic      route_en;
  logic      data_en;
  logic      route_done;
  logic      data_ready;
  logic      data_done;

  tlp_hdr_decoder tlp_hdr_decoder_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .hdr_take_i (hdr_take),
    .rx_i       (rx_i),
    .hdr_info_o (hdr_info)
  );

  tlp_rx_ctrl tlp_rx_ctrl_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .rx_valid_i   (rx_valid_i),
    .rx_sop_i     (rx_i.sop),
    .rx_eop_i     (rx_i.eop),
    .hdr_info_i   (hdr_info),
    .route_done_i (route_done),
    .data_ready_i (data_ready),
    .data_done_i  (data_done),
    .hdr_take_o   (hdr_take),
    .route_en_o   (route_en),
    .data_en_o    (data_en),
    .rx_ready_o   (rx_ready_o)
  );

  tlp_req_router tlp_req_router_i (
    .route_en_i      (route_en),
    .hdr_info_i      (hdr_info),
    .cpl_cmd_o       (cpl_cmd_o),
    .cpl_cmd_valid_o (cpl_cmd_valid_o),
    .cpl_cmd_ready_i (cpl_cmd_ready_i),
    .cfg_req_o       (cfg_req_o),
    .cfg_req_valid_o (cfg_req_valid_o),
    .cfg_req_ready_i (cfg_req_ready_i),
    .route_done_o    (route_done)
  );

  tlp_memwr_aligner tlp_memwr_aligner_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_en_i     (data_en),
    .hdr_info_i    (hdr_info),
    .rx_i          (rx_i),
    .rx_valid_i    (rx_valid_i),
    .memwr_o       (memwr_o),
    .memwr_valid_o (memwr_valid_o),
    .memwr_ready_i (memwr_ready_i),
    .data_ready_o  (data_ready),
    .data_done_o   (data_done)
  );

endmodule

// File: tb_tlp_rx_tasks.svh
// Header beat built from wire fields with a random DW1
function automatic tlp_hdr_t make_hdr(input fmt_e fmt, input logic [4:0] typ,
                                      input logic [9:0] len, input logic [31:0] dw2,
                                      input logic [31:0] dw3);
  tlp_hdr_t h;
  h = '0;
  h.dw0.fmt    = fmt;
  h.dw0.typ    = typ;
  h.dw0.length = len;
  h.dw1        = $random(seed); // Requester ID, tag and BEs
  h.dw2        = dw2;
  h.dw3        = dw3;
  return h;
endfunction

// Drives one beat and holds it until the DUT takes it
task automatic send_beat(input logic [127:0] d, input logic s, input logic e);
  @(negedge clk);
  rx_i.data  = d;
  rx_i.sop   = s;
  rx_i.eop   = e;
  rx_valid_i = 1'b1;
  do @(posedge clk); while (!rx_ready_o);
endtask

// Drops valid and waits until every expected output has drained
task automatic finish_packet();
  @(negedge clk);
  rx_valid_i = 1'b0;
  rx_i       = '0;
  while (exp_memwr_q.size() != 0 || exp_cpl_q.size() != 0 || exp_cfg_q.size() != 0
         || !rx_ready_o)
    @(negedge clk);
endtask

// Completion command model where UR reports no bytes and no address
task automatic push_cpl(input tlp_hdr_t h, input logic is_4dw, input logic ur);
  cpl_cmd_t c;
  c.requester_id = h.dw1.requester_id;
  c.tag          = h.dw1.tag;
  c.first_be     = h.dw1.first_be;
  c.last_be      = h.dw1.last_be;
  c.status       = ur ? UR : SC;
  c.byte_count   = ur ? 12'd0 : 12'(h.dw0.length) * 12'd4;
  c.lower_addr   = ur ? 7'd0 : (is_4dw ? h.dw3[6:0] : h.dw2[6:0]);
  exp_cpl_q.push_back(c);
endtask

// Config request model from the bus/dev/func view of DW2
task automatic push_cfg(input tlp_hdr_t h, input logic is_read);
  cfg_req_t r;
  r.is_read      = is_read;
  r.requester_id = h.dw1.requester_id;
  r.tag          = h.dw1.tag;
  r.first_be     = h.dw1.first_be;
  r.reg_num      = h.dw2[11:2];         // Extended and base register
  r.data         = is_read ? 32'd0 : h.dw3;
  exp_cfg_q.push_back(r);
endtask

// Aligned write beats with payload DW k in beat k/4 lane k%4
task automatic push_mwr(input tlp_hdr_t h, input logic is_4dw, input logic [63:0] a);
  memwr_beat_t m;
  int len;
  int nb;
  int k;
  len = int'(h.dw0.length);
  nb  = (len + 3) / 4;
  for (int b = 0; b < nb; b++) begin
    m = '0;
    for (int i = 0; i < 4; i++) begin
      k = 4 * b + i;
      if (k < len) m.data[32*i +: 32] = payload[k];
      if (k == 0)            m.be[4*i +: 4] = h.dw1.first_be;
      else if (k == len - 1) m.be[4*i +: 4] = h.dw1.last_be;
      else if (k < len)      m.be[4*i +: 4] = 4'hF;
    end
    if (b == 0) m.addr = is_4dw ? a : {32'd0, a[31:0]}; // 3DW is zero-extended
    m.sop = (b == 0);
    m.eop = (b == nb - 1);
    exp_memwr_q.push_back(m);
  end
endtask

// Memory write whose first payload DW rides in the header beat on 3DW
task automatic send_mwr(input logic is_4dw, input int len);
  tlp_hdr_t       h;
  logic [63:0]    a;
  logic [127:0]   d;
  int             base;
  int             nb;
  int             k;
  a = {$random(seed), $random(seed)};
  for (int i = 0; i < 16; i++) payload[i] = $random(seed);
  if (is_4dw) h = make_hdr(FMT_4DW_DATA, TYPE_MEM, 10'(len), a[63:32], a[31:0]);
  else        h = make_hdr(FMT_3DW_DATA, TYPE_MEM, 10'(len), a[31:0], payload[0]);
  base = is_4dw ? 0 : 1;
  push_mwr(h, is_4dw, a);
  send_beat(h, 1'b1, base == len);
  nb = (len - base + 3) / 4;
  for (int j = 0; j < nb; j++) begin
    d = '0; // Unused lanes stay zero
    for (int i = 0; i < 4; i++) begin
      k = base + 4 * j + i;
      if (k < len) d[32*i +: 32] = payload[k];
    end
    send_beat(d, 1'b0, j == nb - 1);
  end
  finish_packet();
endtask

// File: tb_tlp_rx.sv
`timescale 1ns/1ns

module tb_tlp_rx;
  import tlp_hdr_pkg::*;
  import tlp_rx_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int PKT_CNT    = 14;  // Packets in the sequence below

  logic        clk;
  logic        rst_n;
  rx_beat_t    rx_i;
  logic        rx_valid_i;
  logic        rx_ready_o;
  memwr_beat_t memwr_o;
  logic        memwr_valid_o;
  logic        memwr_ready_i;
  cpl_cmd_t    cpl_cmd_o;
  logic        cpl_cmd_valid_o;
  logic        cpl_cmd_ready_i;
  cfg_req_t    cfg_req_o;
  logic        cfg_req_valid_o;
  logic        cfg_req_ready_i;

  integer      seed = 2823;
  string       test_name = "reset";
  logic [31:0] payload [0:15];   // Current write payload
  memwr_beat_t exp_memwr_q[$];
  cpl_cmd_t    exp_cpl_q[$];
  cfg_req_t    exp_cfg_q[$];
  tlp_hdr_t    hdr;
  logic [31:0] cfg_dw;
  logic [31:0] rnd;

  tlp_rx_top tlp_rx_top_i (.*);

  always #(CLK_PERIOD/2) clk = ~clk;

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  `include "tb_tlp_rx_tasks.svh"

  // Random back-pressure with each sink ready about three times in four
  always @(negedge clk) begin
    if (rst_n) begin
      rnd = $random(seed);
      memwr_ready_i   = (rnd[1:0] != 2'b00);
      cpl_cmd_ready_i = (rnd[3:2] != 2'b00);
      cfg_req_ready_i = (rnd[5:4] != 2'b00);
    end
  end

  // Each handshake is checked against the head of its queue
  always @(posedge clk) begin
    if (rst_n && memwr_valid_o && memwr_ready_i) begin
      if (exp_memwr_q.size() == 0) report_fail($sformatf("%s: unexpected write beat", test_name));
      else assert (memwr_o == exp_memwr_q[0]) void'(exp_memwr_q.pop_front());
        else report_fail($sformatf("error %s memwr expected %h actual %h",
                                   test_name, exp_memwr_q[0], memwr_o));
    end
    if (rst_n && cpl_cmd_valid_o && cpl_cmd_ready_i) begin
      if (exp_cpl_q.size() == 0) report_fail($sformatf("%s: unexpected completion", test_name));
      else assert (cpl_cmd_o == exp_cpl_q[0]) void'(exp_cpl_q.pop_front());
        else report_fail($sformatf("error %s cpl_cmd expected %h actual %h",
                                   test_name, exp_cpl_q[0], cpl_cmd_o));
    end
    if (rst_n && cfg_req_valid_o && cfg_req_ready_i) begin
      if (exp_cfg_q.size() == 0) report_fail($sformatf("%s: unexpected config req", test_name));
      else assert (cfg_req_o == exp_cfg_q[0]) void'(exp_cfg_q.pop_front());
        else report_fail($sformatf("error %s cfg_req expected %h actual %h",
                                   test_name, exp_cfg_q[0], cfg_req_o));
    end
  end

  // Watchdog sized from the packet count
  initial begin
    #((PKT_CNT * 200 + 10) * CLK_PERIOD);
    report_fail("timeout: the DUT stopped accepting or producing data");
  end

  initial begin
    clk             = 1'b0;
    rst_n           = 1'b0;
    rx_i            = '0;
    rx_valid_i      = 1'b0;
    memwr_ready_i   = 1'b1;
    cpl_cmd_ready_i = 1'b1;
    cfg_req_ready_i = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk) rst_n = 1'b1;
    assert (!memwr_valid_o && !cpl_cmd_valid_o && !cfg_req_valid_o && rx_ready_o)
      else report_fail("reset state wrong: a valid is high or rx_ready_o is low");

    test_name = "mrd_3dw";
    hdr = make_hdr(FMT_3DW_NODATA, TYPE_MEM, 10'd16, $random(seed), 32'd0);
    push_cpl(hdr, 1'b0, 1'b0);
    send_beat(hdr, 1'b1, 1'b1);
    finish_packet();
    test_name = "mrd_4dw";
    hdr = make_hdr(FMT_4DW_NODATA, TYPE_MEM, 10'd3, $random(seed), $random(seed));
    push_cpl(hdr, 1'b1, 1'b0);
    send_beat(hdr, 1'b1, 1'b1);
    finish_packet();

    // Bus, device, function, extended and base register
    cfg_dw = {8'h12, 5'd3, 3'd1, 4'h0, 4'h5, 6'h2A, 2'b00};
    test_name = "cfg_rd";
    hdr = make_hdr(FMT_3DW_NODATA, TYPE_CFG0, 10'd1, cfg_dw, $random(seed));
    push_cfg(hdr, 1'b1);
    send_beat(hdr, 1'b1, 1'b1);
    finish_packet();
    test_name = "cfg_wr";
    hdr = make_hdr(FMT_3DW_DATA, TYPE_CFG0, 10'd1, cfg_dw ^ 32'h0000_0F04, $random(seed));
    push_cfg(hdr, 1'b0);
    send_beat(hdr, 1'b1, 1'b1);
    finish_packet();

    test_name = "mwr_4dw_len1";
    send_mwr(1'b1, 1);
    test_name = "mwr_4dw_len4";
    send_mwr(1'b1, 4);
    test_name = "mwr_4dw_len9";
    send_mwr(1'b1, 9);
    test_name = "mwr_3dw_len1";
    send_mwr(1'b0, 1);  // Flush beat only
    test_name = "mwr_3dw_len2";
    send_mwr(1'b0, 2);
    test_name = "mwr_3dw_len4";
    send_mwr(1'b0, 4);
    test_name = "mwr_3dw_len5";
    send_mwr(1'b0, 5);  // Ends in a flush beat
    test_name = "mwr_3dw_len8";
    send_mwr(1'b0, 8);

    test_name = "unsupported";
    hdr = make_hdr(FMT_3DW_DATA, 5'b00101, 10'd8, $random(seed), $random(seed)); // CfgWr1
    push_cpl(hdr, 1'b0, 1'b1);
    send_beat(hdr, 1'b1, 1'b0);
    send_beat({$random(seed), $random(seed), $random(seed), $random(seed)}, 1'b0, 1'b0);
    send_beat({$random(seed), $random(seed), $random(seed), $random(seed)}, 1'b0, 1'b1);
    finish_packet();
    test_name = "cpld_discard";
    hdr = make_hdr(FMT_3DW_DATA, TYPE_CPL, 10'd4, $random(seed), $random(seed));
    send_beat(hdr, 1'b1, 1'b0);
    send_beat({$random(seed), $random(seed), $random(seed), $random(seed)}, 1'b0, 1'b1);
    finish_packet();

    repeat (4) @(negedge clk);  // Stray outputs still hit the handshake checks
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: files.f
+incdir+.
tlp_hdr_pkg.sv
tlp_rx_pkg.sv
tlp_hdr_decoder.sv
tlp_rx_ctrl.sv
tlp_req_router.sv
tlp_memwr_aligner.sv
tlp_rx_top.sv
tb_tlp_rx.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the TLP receive parser testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f files.f --top-module tb_tlp_rx -o sim_tlp_rx
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tlp_rx > sim.log 2>&1
status=$?
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
exit 0
